/* serial_rx_settings.svh */
`ifndef SERIAL_RX_SETTINGS_SVH
`define SERIAL_RX_SETTINGS_SVH

`default_nettype none

// Frame width in bits, also the sync window width
`define SRX_DATA_WIDTH 8

// Divider field width, bit period is div+1 clocks
`define SRX_DIV_WIDTH 4

`define SRX_SYNC_RESET 8'hA5 // Pattern loaded at reset

`default_nettype wire

`endif

/* serial_rx_pkg.sv */
`include "serial_rx_settings.svh"

`default_nettype none

package serial_rx_pkg;

    // Control word at address 0, enable in the top bit
    typedef struct packed {
        logic                      enable;    // Whole receive path runs only when set
        logic                      use_sync;  // 1 = start on sync pattern, 0 = on load
        logic                      msb_first; // Bit order of the assembled word
        logic                      spare;     // Stored and read back, no function
        logic [`SRX_DIV_WIDTH-1:0] div;       // Bit period minus one, in clocks
    } rx_ctrl_t;

    // One write word, two readings picked by the address
    typedef union packed {
        rx_ctrl_t                   ctrl;    // Address 0
        logic [`SRX_DATA_WIDTH-1:0] pattern; // Address 1, raw sync pattern
    } rx_cfg_word_u;

    // Everything the receive blocks need from the register block
    typedef struct packed {
        rx_ctrl_t                   ctrl;
        logic [`SRX_DATA_WIDTH-1:0] sync_pat;
    } rx_cfg_t;

endpackage

`default_nettype wire

/* rx_config_regs.sv */
`include "serial_rx_settings.svh"

`default_nettype none

module rx_config_regs (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cfg_we,    // Write strobe, one word per high cycle
    input  logic                       cfg_addr,  // 0 = control, 1 = sync pattern
    input  serial_rx_pkg::rx_cfg_word_u cfg_wdata,
    output logic [7:0]                 cfg_rdata,
    output serial_rx_pkg::rx_cfg_t     cfg
);

    serial_rx_pkg::rx_ctrl_t    ctrl_q;                // Control word register
    logic [`SRX_DATA_WIDTH-1:0] sync_q;                // Sync pattern register

    // Address picks which view of the union is stored
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q <= '0;                              // Disabled, explicit, LSB-first, div 0
            sync_q <= `SRX_SYNC_RESET;
        end else if (cfg_we) begin
            if (cfg_addr) begin
                sync_q <= cfg_wdata.pattern;
            end else begin
                ctrl_q <= cfg_wdata.ctrl;              // Spare bit kept as written
            end
        end
    end

    // Configuration bus seen by the timer, hunter and deserializer
    assign cfg.ctrl     = ctrl_q;
    assign cfg.sync_pat = sync_q;

    // Readback is combinational on the address
    always_comb begin
        if (cfg_addr) begin
            cfg_rdata = sync_q;
        end else begin
            cfg_rdata = ctrl_q;
        end
    end

endmodule

`default_nettype wire

/* bit_sample_timer.sv */
`include "serial_rx_settings.svh"

`default_nettype none

module bit_sample_timer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  serial_rx_pkg::rx_cfg_t cfg,
    input  logic                   frame_start,   // Restart the bit period
    output logic                   sample_strobe  // One cycle per bit period
);

    logic [`SRX_DIV_WIDTH-1:0] cnt; // Position inside the current bit period

    // Counter runs 0..div and holds while disabled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (frame_start) begin
            cnt <= '0;                                 // Align bit boundaries to the frame
        end else if (cfg.ctrl.enable) begin
            if (cnt == cfg.ctrl.div) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;                     // Wraps if div shrank below cnt
            end
        end
    end

    // Strobe on the last count of the period
    assign sample_strobe = cfg.ctrl.enable && (cnt == cfg.ctrl.div);

    // A period longer than one clock never strobes back to back
    a_strobe_spacing: assert property (@(posedge clk) disable iff (!rst_n)
        (sample_strobe && (cfg.ctrl.div != '0)) |=>
            (!sample_strobe || $changed(cfg.ctrl.div)))
        else $error("sample_strobe high on consecutive cycles with div %0d", cfg.ctrl.div);

endmodule

`default_nettype wire

/* sync_hunter.sv */
`include "serial_rx_settings.svh"

`default_nettype none

module sync_hunter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  serial_rx_pkg::rx_cfg_t cfg,
    input  logic                   sample_strobe,
    input  logic                   serial_in,
    input  logic                   busy,     // Deserializer inside a frame
    output logic                   sync_hit  // Pattern seen, one cycle
);

    logic [`SRX_DATA_WIDTH-1:0] window;      // Last sampled bits, oldest in the MSB
    logic [`SRX_DATA_WIDTH-1:0] window_next;

    assign window_next = {window[`SRX_DATA_WIDTH-2:0], serial_in}; // Newest bit at bit 0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            window   <= '0;
            sync_hit <= 1'b0;
        end else begin
            sync_hit <= 1'b0;                          // Pulse only
            if (cfg.ctrl.enable) begin
                if (busy || sync_hit) begin
                    // Payload bits must not build up a false start
                    window <= '0;
                end else if (sample_strobe) begin
                    window   <= window_next;
                    sync_hit <= cfg.ctrl.use_sync && (window_next == cfg.sync_pat);
                end
            end
        end
    end

    // A hit must never overlap a frame in progress
    a_no_hit_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !(sync_hit && busy))
        else $error("sync_hit high while deserializer busy");

endmodule

`default_nettype wire

/* deser_shifter.sv */
`include "serial_rx_settings.svh"

`default_nettype none

module deser_shifter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  serial_rx_pkg::rx_cfg_t     cfg,
    input  logic                       sample_strobe,
    input  logic                       serial_in,
    input  logic                       load,          // Start level, explicit mode only
    input  logic                       sync_hit,      // Start pulse, sync mode only
    output logic                       frame_start,   // To the timer, restarts bit period
    output logic [`SRX_DATA_WIDTH-1:0] parallel_out,
    output logic                       rx_done,
    output logic                       rx_busy
);

    localparam int CNT_W = $clog2(`SRX_DATA_WIDTH);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`SRX_DATA_WIDTH - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RECEIVING,
        ST_DONE       // Explicit mode, waits here for load low
    } state_t;

    state_t                     state;
    logic [CNT_W-1:0]           bit_cnt;    // Bits captured so far in this frame
    logic [`SRX_DATA_WIDTH-1:0] shift_reg;
    logic [`SRX_DATA_WIDTH-1:0] shift_next;
    logic                       start_cond;

    // Start source follows use_sync, the other one is ignored
    assign start_cond  = cfg.ctrl.use_sync ? sync_hit : load;
    assign frame_start = cfg.ctrl.enable && (state == ST_IDLE) && start_cond;

    // MSB-first shifts left, LSB-first shifts right
    always_comb begin
        if (cfg.ctrl.msb_first) begin
            shift_next = {shift_reg[`SRX_DATA_WIDTH-2:0], serial_in};
        end else begin
            shift_next = {serial_in, shift_reg[`SRX_DATA_WIDTH-1:1]};
        end
    end

    // Payload shift register, one bit per strobe while receiving
    always_ff @(posedge clk) begin
        if (cfg.ctrl.enable && (state == ST_RECEIVING) && sample_strobe) begin
            shift_reg <= shift_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            bit_cnt      <= '0;
            parallel_out <= '0;
            rx_done      <= 1'b0;
            rx_busy      <= 1'b0;
        end else begin
            rx_done <= 1'b0;                           // Done is a single-cycle pulse
            if (cfg.ctrl.enable) begin
                case (state)
                    ST_IDLE: begin
                        bit_cnt <= '0;
                        if (frame_start) begin
                            state   <= ST_RECEIVING;
                            rx_busy <= 1'b1;
                        end
                    end
                    ST_RECEIVING: begin
                        if (sample_strobe) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == LAST_BIT) begin
                                // Word complete, present it with the new bit included
                                parallel_out <= shift_next;
                                rx_done      <= 1'b1;
                                rx_busy      <= 1'b0;
                                state        <= cfg.ctrl.use_sync ? ST_IDLE : ST_DONE;
                            end
                        end
                    end
                    ST_DONE: begin
                        if (!load || cfg.ctrl.use_sync) begin
                            state <= ST_IDLE;          // Rearm once load released
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    a_done_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !(rx_done && rx_busy))
        else $error("rx_done and rx_busy high together");

    // Done never stretches, even if enable drops
    a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
        rx_done |=> !rx_done)
        else $error("rx_done high for two cycles");

endmodule

`default_nettype wire

/* serial_rx_top.sv */
`include "serial_rx_settings.svh"

`default_nettype none

module serial_rx_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cfg_we,
    input  logic                        cfg_addr,
    input  serial_rx_pkg::rx_cfg_word_u cfg_wdata,
    output logic [7:0]                  cfg_rdata,
    input  logic                        serial_in,
    input  logic                        load,
    output logic [`SRX_DATA_WIDTH-1:0]  parallel_out,
    output logic                        rx_done,
    output logic                        rx_busy,
    output logic                        sync_detected
);

    serial_rx_pkg::rx_cfg_t cfg;           // Shared configuration bus
    logic                   sample_strobe;
    logic                   sync_hit;
    logic                   frame_start;   // Deserializer restarts the timer

    rx_config_regs u_rx_config_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .cfg       (cfg)
    );

    bit_sample_timer u_bit_sample_timer (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg           (cfg),
        .frame_start   (frame_start),
        .sample_strobe (sample_strobe)
    );

    // Busy from the deserializer keeps the hunter quiet inside a frame
    sync_hunter u_sync_hunter (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg           (cfg),
        .sample_strobe (sample_strobe),
        .serial_in     (serial_in),
        .busy          (rx_busy),
        .sync_hit      (sync_hit)
    );

    deser_shifter u_deser_shifter (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg           (cfg),
        .sample_strobe (sample_strobe),
        .serial_in     (serial_in),
        .load          (load),
        .sync_hit      (sync_hit),
        .frame_start   (frame_start),
        .parallel_out  (parallel_out),
        .rx_done       (rx_done),
        .rx_busy       (rx_busy)
    );

    assign sync_detected = sync_hit; // Hunter pulse straight out

endmodule

`default_nettype wire

/* serial_rx_tb.sv */
`include "serial_rx_settings.svh"

`default_nettype none

module serial_rx_tb;

    localparam int W         = `SRX_DATA_WIDTH;
    localparam int FRAMES    = 4;                      // Frames per explicit-mode test
    localparam int FRAME_MAX = W * 16 + 16;            // Longest frame at div 15, plus slack
    localparam int WATCHDOG_CYCLES = 2 * FRAMES * FRAME_MAX   // Explicit tests
                                   + FRAME_MAX + 64           // Pause test
                                   + 400                      // Readback and sync tests
                                   + 1000;                    // Margin

    logic                        clk;
    logic                        rst_n;
    logic                        cfg_we;
    logic                        cfg_addr;
    serial_rx_pkg::rx_cfg_word_u cfg_wdata;
    logic [7:0]                  cfg_rdata;
    logic                        serial_in;
    logic                        load;
    logic [W-1:0]                parallel_out;
    logic                        rx_done;
    logic                        rx_busy;
    logic                        sync_detected;

    logic [W-1:0] exp_word[$];   // Words expected on rx_done, in order
    int           exp_cyc[$];    // Cycle of each rx_done, -1 when not checked
    int           exp_rd;        // Next entry to compare
    int           cyc;           // Free-running cycle count
    int           sync_cnt;      // sync_detected pulses seen
    int           err_cnt;
    int           tests_run;
    int           tests_failed;
    logic [7:0]   ctrl_now;      // Last control word written
    logic [7:0]   rd_exp;
    logic         rd_chk;        // Readback compare this cycle
    logic         chk_reset;
    logic         in_frame;      // rx_busy must be high
    logic         hold_chk;      // rx_busy must stay low, load still high
    logic         paused;        // No rx_done allowed
    logic         hit_ok;        // Window where sync_detected may pulse

    serial_rx_top u_serial_rx_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_we        (cfg_we),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .cfg_rdata     (cfg_rdata),
        .serial_in     (serial_in),
        .load          (load),
        .parallel_out  (parallel_out),
        .rx_done       (rx_done),
        .rx_busy       (rx_busy),
        .sync_detected (sync_detected)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (rst_n && rx_done) exp_rd <= exp_rd + 1;          // Pop on each done
        if (rst_n && sync_detected) sync_cnt <= sync_cnt + 1;
    end

    a_word: assert property (@(posedge clk) disable iff (!rst_n)
        rx_done |-> (exp_rd < exp_word.size()) && (parallel_out == exp_word[exp_rd]))
        else begin
            err_cnt++;
            $display("error t=%0t parallel_out got %h expected %h", $time,
                     $sampled(parallel_out), exp_word[$sampled(exp_rd)]);
        end

    // Done lands a fixed number of cycles after the load edge
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        rx_done |-> (exp_cyc[exp_rd] < 0) || (cyc == exp_cyc[exp_rd]))
        else begin
            err_cnt++;
            $display("error t=%0t rx_done cycle got %0d expected %0d", $time,
                     $sampled(cyc), exp_cyc[$sampled(exp_rd)]);
        end

    a_busy: assert property (@(posedge clk) disable iff (!rst_n) in_frame |-> rx_busy)
        else begin
            err_cnt++;
            $display("error t=%0t rx_busy got 0 expected 1", $time);
        end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n) hold_chk |-> !rx_busy)
        else begin
            err_cnt++;
            $display("error t=%0t rx_busy got 1 expected 0", $time);
        end

    a_pause: assert property (@(posedge clk) disable iff (!rst_n) paused |-> !rx_done)
        else begin
            err_cnt++;
            $display("error t=%0t rx_done got 1 expected 0 while enable cleared", $time);
        end

    a_sync: assert property (@(posedge clk) disable iff (!rst_n) sync_detected |-> hit_ok)
        else begin
            err_cnt++;
            $display("error t=%0t sync_detected got 1 expected 0 without a pattern", $time);
        end

    a_reset: assert property (@(posedge clk)
        chk_reset |-> !rx_done && !rx_busy && !sync_detected && (parallel_out == '0))
        else begin
            err_cnt++;
            $display("error t=%0t {rx_done,rx_busy,sync_detected,parallel_out} got %h expected 0",
                     $time, $sampled({rx_done, rx_busy, sync_detected, parallel_out}));
        end

    a_rdback: assert property (@(posedge clk) disable iff (!rst_n) rd_chk |-> cfg_rdata == rd_exp)
        else begin
            err_cnt++;
            $display("error t=%0t cfg_rdata got %h expected %h", $time,
                     $sampled(cfg_rdata), $sampled(rd_exp));
        end

    // Field order enable, use_sync, msb_first, spare, div
    function automatic logic [7:0] make_ctrl(input logic en, input logic us,
                                             input logic msb, input int div);
        return {en, us, msb, 1'b0, 4'(div)};
    endfunction

    function automatic logic [W-1:0] reverse_bits(input logic [W-1:0] d);
        logic [W-1:0] r;
        for (int i = 0; i < W; i++) r[i] = d[W-1-i];
        return r;
    endfunction

    task automatic write_cfg(input logic addr, input logic [7:0] data);
        @(negedge clk);
        cfg_we            = 1'b1;
        cfg_addr          = addr;
        cfg_wdata.pattern = data;
        if (!addr) ctrl_now = data;
        @(negedge clk);
        cfg_we = 1'b0;                                 // Visible from here on
    endtask

    task automatic check_readback(input logic addr, input logic [7:0] exp);
        cfg_addr = addr;
        rd_exp   = exp;
        rd_chk   = 1'b1;
        @(negedge clk);
        rd_chk = 1'b0;
    endtask

    // Clears enable for len cycles, called on a negedge
    task automatic pause_enable(input int len);
        cfg_we            = 1'b1;
        cfg_addr          = 1'b0;
        cfg_wdata.pattern = ctrl_now & 8'h7F;
        @(negedge clk);
        cfg_we = 1'b0;
        paused = 1'b1;
        repeat (len - 1) @(negedge clk);
        cfg_we            = 1'b1;
        cfg_wdata.pattern = ctrl_now;
        @(negedge clk);
        cfg_we = 1'b0;
        paused = 1'b0;
    endtask

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        while (!rx_done && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!rx_done) begin
            err_cnt++;
            $display("rx_done did not arrive within %0d cycles", limit);
        end
    endtask

    // Explicit frame, first-sent bit is data MSB
    task automatic send_frame(input logic [W-1:0] data, input int div,
                              input int pause_bit, input int pause_len);
        int   c0;
        logic at_neg;
        @(negedge clk);
        load = 1'b0;                                   // Rearm the FSM
        @(negedge clk);
        load = 1'b1;
        @(posedge clk);                                // Frame start edge
        @(negedge clk);
        c0       = cyc;
        in_frame = 1'b1;
        exp_word.push_back(ctrl_now[5] ? data : reverse_bits(data));
        exp_cyc.push_back(c0 + W * (div + 1) + ((pause_bit >= 0) ? pause_len : 0));
        at_neg = 1'b1;
        for (int i = 0; i < W; i++) begin
            if (!at_neg) @(negedge clk);
            at_neg    = 1'b0;
            serial_in = data[W-1-i];
            if (i == pause_bit) begin
                pause_enable(pause_len);
                if (div == 0) at_neg = 1'b1;           // Bit already sampled before pause
                else repeat (div) @(posedge clk);
            end else begin
                repeat (div + 1) @(posedge clk);
            end
        end
        if (!at_neg) @(negedge clk);
        in_frame = 1'b0;
        wait_done(4);
        hold_chk = 1'b1;                               // Load still high, no new frame
        repeat (3) @(negedge clk);
        hold_chk = 1'b0;
    endtask

    task automatic drive_bit(input logic b);
        @(negedge clk);
        serial_in = b;
        load      = 1'($urandom % 2);                  // Ignored in sync mode
    endtask

    task automatic run_explicit(input logic msb);
        int           div;
        logic [W-1:0] data;
        for (int f = 0; f < FRAMES; f++) begin
            div  = int'($urandom % 16);
            data = W'($urandom);
            write_cfg(1'b0, make_ctrl(1'b1, 1'b0, msb, div));
            send_frame(data, div, -1, 0);
        end
    endtask

    task automatic run_sync();
        logic [W-1:0] pat;
        logic [W-1:0] win;
        logic [W-1:0] cand;
        logic [W-1:0] mask;
        logic [W-1:0] data;
        logic         b;
        int           s0;
        pat = `SRX_SYNC_RESET;
        win = '0;
        s0  = sync_cnt;
        write_cfg(1'b0, make_ctrl(1'b1, 1'b1, 1'b1, 0));
        // Timer counter may run up to its wrap before strobing every cycle
        repeat (1 << `SRX_DIV_WIDTH) drive_bit(serial_in);
        // Older window bits are unknown, so a partial window matching the pattern tail is avoided
        for (int n = 0; n < 3 * W; n++) begin
            b    = 1'($urandom % 2);
            cand = {win[W-2:0], b};
            mask = (n + 1 < W) ? W'((1 << (n + 1)) - 1) : '1;
            if ((cand & mask) == (pat & mask)) begin
                b    = ~b;
                cand = {win[W-2:0], b};
            end
            win = cand;
            drive_bit(b);
        end
        for (int p = 0; p < 2; p++) begin
            data = W'($urandom);
            exp_word.push_back(data);
            exp_cyc.push_back(-1);
            for (int i = 0; i < W; i++) begin
                drive_bit(pat[W-1-i]);
                if (i == W - 1) hit_ok = 1'b1;
            end
            drive_bit(1'b0);                           // Sampled on the frame start edge
            for (int i = 0; i < W; i++) begin
                drive_bit(data[W-1-i]);
                if (i == 0) hit_ok = 1'b0;
            end
            wait_done(4);
        end
        load = 1'b0;
        if (sync_cnt - s0 != 2) begin
            err_cnt++;
            $display("sync_detected pulsed %0d times for 2 patterns", sync_cnt - s0);
        end
    endtask

    task automatic report_test(input string name, input int e0);
        tests_run++;
        if (err_cnt > e0) tests_failed++;
        $display("test %s: %s (%0d errors)", name, (err_cnt > e0) ? "failed" : "ok",
                 err_cnt - e0);
    endtask

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int           e0;
        int           div;
        logic [7:0]   val;
        logic [W-1:0] data;
        void'($urandom(1));
        clk       = 1'b0;
        rst_n     = 1'b0;
        cfg_we    = 1'b0;
        cfg_addr  = 1'b0;
        cfg_wdata = '0;
        serial_in = 1'b0;
        load      = 1'b0;
        ctrl_now  = '0;
        rd_exp    = '0;
        rd_chk    = 1'b0;
        chk_reset = 1'b0;
        in_frame  = 1'b0;
        hold_chk  = 1'b0;
        paused    = 1'b0;
        hit_ok    = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        e0        = err_cnt;
        chk_reset = 1'b1;
        check_readback(1'b1, `SRX_SYNC_RESET);
        check_readback(1'b0, 8'h00);
        chk_reset = 1'b0;
        for (int i = 0; i < 8; i++) begin
            val = 8'($urandom) & 8'h7F;                // Enable off, spare random
            write_cfg(1'b0, val);
            check_readback(1'b0, val);
            val = 8'($urandom);
            write_cfg(1'b1, val);
            check_readback(1'b1, val);
        end
        write_cfg(1'b1, `SRX_SYNC_RESET);
        report_test("reset and readback", e0);

        e0 = err_cnt;
        run_explicit(1'b1);
        report_test("explicit msb-first", e0);

        e0 = err_cnt;
        run_explicit(1'b0);
        report_test("explicit lsb-first", e0);

        e0 = err_cnt;
        run_sync();
        report_test("sync mode", e0);

        e0   = err_cnt;
        div  = int'($urandom % 16);
        data = W'($urandom);
        write_cfg(1'b0, make_ctrl(1'b1, 1'b0, 1'b1, div));
        send_frame(data, div, 1 + int'($urandom % 5), 1 + int'($urandom % 20));
        report_test("enable pause", e0);

        repeat (2) @(negedge clk);
        if (exp_rd != exp_word.size()) begin
            err_cnt++;
            $display("%0d expected words never arrived", exp_word.size() - exp_rd);
        end
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* serial_rx_top.f */
+incdir+.
serial_rx_pkg.sv
rx_config_regs.sv
bit_sample_timer.sv
sync_hunter.sv
deser_shifter.sv
serial_rx_top.sv
serial_rx_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := serial_rx_tb
FILELIST  := serial_rx_top.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
LOG       := sim.log

SRCS := $(filter-out +incdir%,$(shell cat $(FILELIST))) $(wildcard *.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then exit 1; fi
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
